// ==== files.f ====
verilog/led_panel_pkg.sv
verilog/quad_decoder.sv
verilog/pattern_writer.sv
verilog/frame_buffer.sv
verilog/panel_scanner.sv
verilog/hex_digit.sv
verilog/led_panel_top.sv
verification/clock_gen.sv
verification/led_panel_props.sv
verification/led_panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module led_panel_tb \
  -Mdir obj_dir -o led_panel_sim

status=0
./obj_dir/led_panel_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int period       = 20,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/led_panel_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_props (
  input logic clk,
  input logic rst_n,
  input logic rgb_clk,
  input logic rgb_stb,
  input logic oe_n,
  input logic rgb_a,
  input logic rgb_b,
  input logic rgb_c
);

  logic [2:0] row_addr;

  assign row_addr = {rgb_c, rgb_b, rgb_a};

  // Nothing shifts or latches while the LEDs are lit
  dark_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
    (rgb_clk || rgb_stb) |-> oe_n)
    else $error("shift clock or strobe high while outputs are enabled");

  strobe_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    rgb_stb |=> !rgb_stb)
    else $error("strobe longer than one cycle");

  // Row lines may only move once the panel is dark again
  row_stable_when_lit: assert property (@(posedge clk) disable iff (!rst_n)
    !oe_n |=> (oe_n || $stable(row_addr)))
    else $error("row address changed while outputs are enabled");

endmodule

`default_nettype wire

// ==== verification/led_panel_stim.txt ====
// direction (01 up, 00 down), pulse count, expected step after the move
// all columns in hex
01 03 03
01 05 08
01 0a 12
01 05 17
01 01 00
01 02 02
00 02 00
00 01 17
00 04 13
01 07 02
00 03 17

// ==== verification/led_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb;
  import led_panel_pkg::*;

  localparam int enc_steps    = 24;
  localparam int on_base      = 4;
  localparam int phase_cycles = 4;
  localparam int line_cycles  = bcm_planes * (2 * panel_cols + 1) + on_base * 15;
  localparam int scan_cycles  = scan_lines * line_cycles;
  localparam int frame_cycles = panel_rows * panel_cols;

  logic       clk;
  logic       rst_n;
  logic       quad_a;
  logic       quad_b;
  logic [2:0] rgb0;
  logic [2:0] rgb1;
  logic       rgb_a;
  logic       rgb_b;
  logic       rgb_c;
  logic       rgb_clk;
  logic       rgb_stb;
  logic       oe_n;
  logic [6:0] hex0;
  logic [6:0] hex1;

  logic [7:0]           stim_mem [64];
  int                   n_lines;
  int                   timeout_cycles = 3 * scan_cycles;
  int                   cycle_count = 0;
  logic [step_bits-1:0] exp_step = '0;
  logic                 data_check = 1'b0;
  int                   data_samples = 0;

  // Scan tracking state
  int   row_now;
  int   col_count = 0;
  int   tb_plane = 0;
  int   disp_plane = 0;
  int   exp_line = 0;
  int   on_len = 0;
  int   prev_on_len = 0;
  int   seen_rows = 0;
  int   stb_count = 0;
  logic prev_stb = 1'b0;
  logic prev_oe = 1'b1;
  int   prev_row = 0;

  clock_gen #(.period(20), .reset_cycles(2)) clock_gen_inst (.clk(clk), .rst_n(rst_n));

  led_panel_top #(.enc_steps(enc_steps), .on_base(on_base)) led_panel_top_inst (
    .clk(clk), .rst_n(rst_n), .quad_a(quad_a), .quad_b(quad_b),
    .rgb0(rgb0), .rgb1(rgb1), .rgb_a(rgb_a), .rgb_b(rgb_b), .rgb_c(rgb_c),
    .rgb_clk(rgb_clk), .rgb_stb(rgb_stb), .oe_n(oe_n), .hex0(hex0), .hex1(hex1)
  );

  bind panel_scanner led_panel_props led_panel_props_inst (
    .clk(clk), .rst_n(rst_n), .rgb_clk(rgb_clk), .rgb_stb(rgb_stb), .oe_n(oe_n),
    .rgb_a(rgb_a), .rgb_b(rgb_b), .rgb_c(rgb_c)
  );

  // Standard active-low digit patterns with segment a on bit 0
  function automatic logic [6:0] seven_seg(input int n);
    case (n)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0010000;
      10: return 7'b0001000;
      11: return 7'b0000011;
      12: return 7'b1000110;
      13: return 7'b0100001;
      14: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  function automatic int seg_value(input logic [6:0] seg);
    int n;
    for (n = 0; n < 16; n++) begin
      if (seven_seg(n) == seg) return n;
    end
    return -1;
  endfunction

  // Plane k shows bit 4+k of each channel from the pixel rule
  function automatic logic [2:0] expected_bits(input int row, input int col,
                                               input int stp, input int plane);
    int sh;
    int red;
    int green;
    int blue;
    sh    = 4 + plane;
    red   = (((col * 8) % 256) >> sh) & 1;
    green = (((row * 16) % 256) >> sh) & 1;
    blue  = (((stp * 10) % 256) >> sh) & 1;
    return 3'((blue << 2) | (green << 1) | red);
  endfunction

  task automatic fail_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_step(input logic [step_bits-1:0] got,
                            input logic [step_bits-1:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s shows step %0d, expected %0d", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_seg(input logic [6:0] got, input logic [6:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_color(input logic [2:0] got, input logic [2:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic read_digits(output logic [step_bits-1:0] value);
    int lo;
    int hi;
    lo = seg_value(hex0);
    hi = seg_value(hex1);
    if (lo < 0 || hi < 0) fail_run("a digit shows a pattern that is no hex value");
    value = step_bits'(hi * 16 + lo);
  endtask

  task automatic set_phase(input logic a, input logic b);
    @(negedge clk);
    quad_a = a;
    quad_b = b;
    repeat (phase_cycles - 1) @(negedge clk);
  endtask

  // A leads B for up and B leads A for down
  task automatic move_encoder(input logic up, input int pulses);
    repeat (pulses) begin
      if (up) begin
        set_phase(1'b1, 1'b0);
        set_phase(1'b1, 1'b1);
        set_phase(1'b0, 1'b1);
        set_phase(1'b0, 1'b0);
      end else begin
        set_phase(1'b0, 1'b1);
        set_phase(1'b1, 1'b1);
        set_phase(1'b1, 1'b0);
        set_phase(1'b0, 1'b0);
      end
    end
  endtask

  task automatic load_stim();
    int i;
    for (i = 0; i < 64; i++) begin
      stim_mem[6'(i)] = 8'hff;
    end
    $readmemh("verification/led_panel_stim.txt", stim_mem);
    n_lines = 0;
    while (n_lines < 21 && stim_mem[6'(3 * n_lines)] !== 8'hff) begin
      n_lines++;
    end
    if (n_lines == 0) fail_run("stim file is missing or empty");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // Panel monitor sampled mid-cycle where the outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      row_now = int'({rgb_c, rgb_b, rgb_a});
      if ((rgb_clk || rgb_stb) && !oe_n) fail_run("panel loaded while outputs enabled");
      if (rgb_stb && prev_stb) fail_run("strobe held high for more than one cycle");
      if (!oe_n && !prev_oe && row_now != prev_row) fail_run("row moved while lit");
      if (rgb_clk) begin
        if (col_count >= panel_cols) fail_run("more shift clocks than columns before strobe");
        if (data_check) begin
          check_color(rgb0, expected_bits(row_now, col_count, int'(exp_step), tb_plane),
                      $sformatf("rgb0 row %0d col %0d plane %0d", row_now, col_count, tb_plane));
          check_color(rgb1, expected_bits(row_now + scan_lines, col_count, int'(exp_step),
                      tb_plane), $sformatf("rgb1 row %0d col %0d plane %0d",
                      row_now + scan_lines, col_count, tb_plane));
          data_samples++;
        end
        col_count++;
      end
      if (rgb_stb) begin
        check_count(col_count, panel_cols, "shift clocks before strobe");
        check_count(row_now, exp_line, "row address at strobe");
        seen_rows  = seen_rows | (1 << row_now);
        disp_plane = tb_plane;
        if (tb_plane == bcm_planes - 1) exp_line = (exp_line + 1) % scan_lines;
        tb_plane  = (tb_plane + 1) % bcm_planes;
        col_count = 0;
        stb_count++;
      end
      if (!oe_n) begin
        on_len++;
      end else if (on_len > 0) begin
        check_count(on_len, on_base << disp_plane, $sformatf("on time of plane %0d", disp_plane));
        if (disp_plane > 0) check_count(on_len, 2 * prev_on_len, "on time against prior plane");
        prev_on_len = on_len;
        on_len = 0;
      end
      prev_stb = rgb_stb;
      prev_oe  = oe_n;
      prev_row = row_now;
    end
  end

  initial begin
    int                   i;
    logic                 up;
    int                   pulses;
    logic [step_bits-1:0] want;
    logic [step_bits-1:0] shown;
    quad_a = 1'b0;
    quad_b = 1'b0;
    load_stim();
    timeout_cycles = n_lines * 2 * scan_cycles + 3 * scan_cycles;

    // Reset state inside reset and again after release
    @(negedge clk);
    read_digits(shown);
    check_step(shown, '0, "digits in reset");
    check_seg(hex0, seven_seg(0), "hex0 in reset");
    check_seg(hex1, seven_seg(0), "hex1 in reset");
    check_count(int'(oe_n), 1, "oe_n in reset");
    check_color(rgb0, 3'b000, "rgb0 in reset");
    check_color(rgb1, 3'b000, "rgb1 in reset");
    wait (rst_n === 1'b1);
    @(negedge clk);
    read_digits(shown);
    check_step(shown, '0, "digits after reset");

    for (i = 0; i < n_lines; i++) begin
      up     = (stim_mem[6'(3 * i)] == 8'h01);
      pulses = int'(stim_mem[6'(3 * i + 1)]);
      want   = step_bits'(stim_mem[6'(3 * i + 2)]);
      move_encoder(up, pulses);
      read_digits(shown);
      check_step(shown, want, $sformatf("digits after stim line %0d", i));
      check_seg(hex0, seven_seg(int'(want) % 16), "hex0 after move");
      exp_step = want;
      // Let the writer cover a whole frame and then check one full scan
      repeat (frame_cycles + 8) @(negedge clk);
      data_samples = 0;
      @(posedge clk);
      data_check = 1'b1;
      repeat (scan_cycles) @(posedge clk);
      data_check = 1'b0;
      check_count(data_samples, scan_lines * bcm_planes * panel_cols, "data samples per scan");
    end

    @(negedge clk);
    if (seen_rows == 255 && stb_count >= scan_lines * bcm_planes) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Error: scan did not visit all 8 row addresses");
      $display("Test failures found");
      $fatal(1, "scan did not cover every row");
    end
  end

endmodule

`default_nettype wire

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  logic                                 clk,
  input  logic                                 wr_en,
  input  logic [led_panel_pkg::row_bits-1:0]   wr_row,
  input  logic [led_panel_pkg::col_bits-1:0]   wr_col,
  input  logic [led_panel_pkg::pixel_bits-1:0] wr_pixel,
  input  logic [led_panel_pkg::line_bits-1:0]  rd_row,
  input  logic [led_panel_pkg::col_bits-1:0]   rd_col,
  output logic [led_panel_pkg::pixel_bits-1:0] upper_pixel,
  output logic [led_panel_pkg::pixel_bits-1:0] lower_pixel
);
  import led_panel_pkg::*;

  localparam int bank_depth = scan_lines * panel_cols;
  localparam int addr_bits  = line_bits + col_bits;

  // Bank 0 holds the upper half, bank 1 the lower half
  logic [pixel_bits-1:0] bank_mem [2][bank_depth];
  logic [addr_bits-1:0]  wr_addr;
  logic [addr_bits-1:0]  rd_addr;

  assign wr_addr = {wr_row[line_bits-1:0], wr_col};
  assign rd_addr = {rd_row, rd_col};

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bank_mem[wr_row[row_bits-1]][wr_addr] <= wr_pixel;
    end
  end

  // Same address into both banks, so the two halves come out together
  always_ff @(posedge clk) begin
    upper_pixel <= bank_mem[0][rd_addr];
    lower_pixel <= bank_mem[1][rd_addr];
  end

endmodule

`default_nettype wire

// ==== verilog/hex_digit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_digit (
  input  logic [3:0] nibble,
  output logic [6:0] seg
);

  // Active low, segment g on bit 6
  always_comb begin
    case (nibble)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/led_panel_pkg.sv ====
`default_nettype none

package led_panel_pkg;

  // Panel geometry
  localparam int panel_cols = 32;
  localparam int panel_rows = 16;
  localparam int scan_lines = panel_rows / 2;
  localparam int col_bits   = $clog2(panel_cols);
  localparam int row_bits   = $clog2(panel_rows);
  localparam int line_bits  = $clog2(scan_lines);

  // Pixel is blue:green:red, red in the low byte
  localparam int color_bits = 8;
  localparam int pixel_bits = 3 * color_bits;
  localparam int red_lsb    = 0;
  localparam int green_lsb  = color_bits;
  localparam int blue_lsb   = 2 * color_bits;

  // Modulation uses the top channel bits only
  localparam int bcm_planes = 4;
  localparam int plane_lsb  = color_bits - bcm_planes;

  localparam int step_bits  = 5;

  // Demo pattern scale factors
  localparam int red_scale   = 8;
  localparam int green_scale = 16;
  localparam int blue_scale  = 10;

endpackage

`default_nettype wire

// ==== verilog/led_panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_panel_top #(
  parameter int enc_steps = 24,
  parameter int on_base   = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       quad_a,
  input  logic       quad_b,
  output logic [2:0] rgb0,
  output logic [2:0] rgb1,
  output logic       rgb_a,
  output logic       rgb_b,
  output logic       rgb_c,
  output logic       rgb_clk,
  output logic       rgb_stb,
  output logic       oe_n,
  output logic [6:0] hex0,
  output logic [6:0] hex1
);
  import led_panel_pkg::*;

  logic [step_bits-1:0]  step;
  logic                  wr_en;
  logic [row_bits-1:0]   wr_row;
  logic [col_bits-1:0]   wr_col;
  logic [pixel_bits-1:0] wr_pixel;
  logic [line_bits-1:0]  rd_row;
  logic [col_bits-1:0]   rd_col;
  logic [pixel_bits-1:0] upper_pixel;
  logic [pixel_bits-1:0] lower_pixel;

  quad_decoder #(.enc_steps(enc_steps)) quad_decoder_inst (
    .clk(clk), .rst_n(rst_n), .quad_a(quad_a), .quad_b(quad_b), .step(step)
  );

  pattern_writer pattern_writer_inst (
    .clk(clk), .rst_n(rst_n), .step(step),
    .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_pixel(wr_pixel)
  );

  frame_buffer frame_buffer_inst (
    .clk(clk), .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_pixel(wr_pixel),
    .rd_row(rd_row), .rd_col(rd_col), .upper_pixel(upper_pixel), .lower_pixel(lower_pixel)
  );

  panel_scanner #(.on_base(on_base)) panel_scanner_inst (
    .clk(clk), .rst_n(rst_n), .upper_pixel(upper_pixel), .lower_pixel(lower_pixel),
    .rd_row(rd_row), .rd_col(rd_col), .rgb0(rgb0), .rgb1(rgb1),
    .rgb_a(rgb_a), .rgb_b(rgb_b), .rgb_c(rgb_c),
    .rgb_clk(rgb_clk), .rgb_stb(rgb_stb), .oe_n(oe_n)
  );

  // Step shown as two hex digits
  hex_digit hex_lo_inst (.nibble(step[3:0]), .seg(hex0));
  hex_digit hex_hi_inst (.nibble(4'(step >> 4)), .seg(hex1));

endmodule

`default_nettype wire

// ==== verilog/panel_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_scanner #(
  parameter int on_base = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [led_panel_pkg::pixel_bits-1:0] upper_pixel,
  input  logic [led_panel_pkg::pixel_bits-1:0] lower_pixel,
  output logic [led_panel_pkg::line_bits-1:0]  rd_row,
  output logic [led_panel_pkg::col_bits-1:0]   rd_col,
  output logic [2:0]                           rgb0,
  output logic [2:0]                           rgb1,
  output logic                                 rgb_a,
  output logic                                 rgb_b,
  output logic                                 rgb_c,
  output logic                                 rgb_clk,
  output logic                                 rgb_stb,
  output logic                                 oe_n
);
  import led_panel_pkg::*;

  localparam int cnt_bits   = $clog2(2 * panel_cols);
  localparam int plane_bits = $clog2(bcm_planes);
  localparam int on_bits    = $clog2(on_base << (bcm_planes - 1));

  localparam logic [cnt_bits-1:0] shift_last = cnt_bits'(2 * panel_cols - 1);

  localparam logic [1:0] st_shift   = 2'd0;
  localparam logic [1:0] st_latch   = 2'd1;
  localparam logic [1:0] st_display = 2'd2;

  logic [1:0]            state;
  logic [1:0]            nxt_state;
  logic [cnt_bits-1:0]   cnt;
  logic [cnt_bits-1:0]   nxt_cnt;
  logic [plane_bits-1:0] plane;
  logic [plane_bits-1:0] nxt_plane;
  logic [line_bits-1:0]  line;
  logic [line_bits-1:0]  nxt_line;
  logic [on_bits-1:0]    on_cnt;
  logic [on_bits-1:0]    nxt_on;

  // Bit 4+k of red, green and blue
  function automatic logic [2:0] plane_slice(input logic [pixel_bits-1:0] pixel,
                                             input logic [plane_bits-1:0] sel);
    logic [2:0] bits;
    bits[0] = pixel[red_lsb + plane_lsb + sel];
    bits[1] = pixel[green_lsb + plane_lsb + sel];
    bits[2] = pixel[blue_lsb + plane_lsb + sel];
    return bits;
  endfunction

  always_comb begin
    nxt_state = state;
    nxt_cnt   = cnt;
    nxt_plane = plane;
    nxt_line  = line;
    nxt_on    = on_cnt;
    case (state)
      st_shift: begin
        if (cnt == shift_last) begin
          nxt_state = st_latch;
          nxt_cnt   = '0;
        end else begin
          nxt_cnt = cnt + 1'b1;
        end
      end
      st_latch: begin
        nxt_state = st_display;
        nxt_on    = on_bits'((on_base << plane) - 1);
      end
      default: begin
        if (on_cnt == '0) begin
          nxt_state = st_shift;
          if (plane == plane_bits'(bcm_planes - 1)) begin
            nxt_plane = '0;
            nxt_line  = (line == line_bits'(scan_lines - 1)) ? '0 : line + 1'b1;
          end else begin
            nxt_plane = plane + 1'b1;
          end
        end else begin
          nxt_on = on_cnt - 1'b1;
        end
      end
    endcase
  end

  // Prefetch: buffer address follows the next state
  assign rd_row = nxt_line;
  assign rd_col = nxt_cnt[cnt_bits-1:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= st_shift;
      cnt    <= '0;
      plane  <= '0;
      line   <= '0;
      on_cnt <= '0;
    end else begin
      state  <= nxt_state;
      cnt    <= nxt_cnt;
      plane  <= nxt_plane;
      line   <= nxt_line;
      on_cnt <= nxt_on;
    end
  end

  // Panel pins lag the state by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb0    <= 3'b000;
      rgb1    <= 3'b000;
      rgb_a   <= 1'b0;
      rgb_b   <= 1'b0;
      rgb_c   <= 1'b0;
      rgb_clk <= 1'b0;
      rgb_stb <= 1'b0;
      oe_n    <= 1'b1;
    end else begin
      rgb0    <= (state == st_shift) ? plane_slice(upper_pixel, plane) : 3'b000;
      rgb1    <= (state == st_shift) ? plane_slice(lower_pixel, plane) : 3'b000;
      rgb_a   <= line[0];
      rgb_b   <= line[1];
      rgb_c   <= line[2];
      rgb_clk <= (state == st_shift) & cnt[0];
      rgb_stb <= (state == st_latch);
      oe_n    <= (state != st_display);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pattern_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_writer (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [led_panel_pkg::step_bits-1:0]  step,
  output logic                                 wr_en,
  output logic [led_panel_pkg::row_bits-1:0]   wr_row,
  output logic [led_panel_pkg::col_bits-1:0]   wr_col,
  output logic [led_panel_pkg::pixel_bits-1:0] wr_pixel
);
  import led_panel_pkg::*;

  logic [row_bits-1:0]   sweep_row;
  logic [col_bits-1:0]   sweep_col;
  logic [color_bits-1:0] red;
  logic [color_bits-1:0] green;
  logic [color_bits-1:0] blue;

  assign red   = color_bits'(sweep_col * red_scale);
  assign green = color_bits'(sweep_row * green_scale);
  assign blue  = color_bits'(step * blue_scale);

  // Row-major sweep, one pixel per clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_row <= '0;
      sweep_col <= '0;
      wr_en     <= 1'b0;
    end else begin
      wr_en <= 1'b1;
      if (sweep_col == col_bits'(panel_cols - 1)) begin
        sweep_col <= '0;
        sweep_row <= (sweep_row == row_bits'(panel_rows - 1)) ? '0 : sweep_row + 1'b1;
      end else begin
        sweep_col <= sweep_col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_row   <= sweep_row;
    wr_col   <= sweep_col;
    wr_pixel <= {blue, green, red};
  end

endmodule

`default_nettype wire

// ==== verilog/quad_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_decoder #(
  parameter int enc_steps = 24
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                quad_a,
  input  logic                                quad_b,
  output logic [led_panel_pkg::step_bits-1:0] step
);
  import led_panel_pkg::*;

  localparam logic [step_bits-1:0] top_step = step_bits'(enc_steps - 1);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_state;
  logic       a_rise;

  // Level only moves when both sync stages agree
  assign a_rise = a_sync[1] & a_sync[0] & ~a_state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_sync  <= 2'b00;
      b_sync  <= 2'b00;
      a_state <= 1'b0;
      step    <= '0;
    end else begin
      a_sync <= {a_sync[0], quad_a};
      b_sync <= {b_sync[0], quad_b};
      if (a_sync[1] == a_sync[0]) begin
        a_state <= a_sync[1];
      end
      if (a_rise) begin
        // B low means clockwise
        if (!b_sync[1]) begin
          step <= (step == top_step) ? '0 : step + 1'b1;
        end else begin
          step <= (step == '0) ? top_step : step - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire
